//--- src.f
logic/fpFormatPkg.sv
logic/fpOpPkg.sv
logic/fmaStageIfs.sv
logic/fmaMul.sv
logic/fmaSum.sv
logic/resultSign.sv
logic/fmaRound.sv
logic/miniFma.sv
test/tbClock.sv
test/fmaChecker.sv
test/miniFmaTb.sv

//--- run.sh
#!/bin/sh
# build and run the miniFma testbench with Verilator
set -e
cd "$(dirname "$0")"

rm -rf obj_dir
verilator --binary --timing --top-module miniFmaTb -f src.f -o miniFmaSim
./obj_dir/miniFmaSim | tee sim.log

if grep -qx "TEST OK" sim.log; then
  echo "simulation passed"
else
  echo "simulation failed"
  exit 1
fi

//--- test/miniFmaTb.sv
// minifloat fma testbench
module miniFmaTb;
  timeunit 1ns;
  timeprecision 100ps;
  import fpFormatPkg::*;
  import fpOpPkg::*;

  localparam int clkPeriod   = 20;
  localparam int randomOps   = 200;
  // directed operations stay below this count
  localparam int directedOps = 100;
  // reset plus drain after each of the five tests
  localparam int slackCycles = 10 + 5 * 10;
  localparam int limitCycles = directedOps + randomOps + slackCycles;

  logic       clk;
  logic       arstN;
  logic       inValid;
  mini_t      a;
  mini_t      b;
  mini_t      c;
  fmaOp_e     op;
  roundMode_e rm;
  logic       outValid;
  mini_t      result;
  int         checks;
  int         errors;
  int         pending;
  int         tbErrors;
  int         lastChecks;
  int         lastErrors;

  tbClock #(.period(clkPeriod), .resetCycles(4)) u_clock (
    .clk   (clk),
    .arstN (arstN)
  );

  miniFma u_miniFma (
    .clk      (clk),
    .arstN    (arstN),
    .inValid  (inValid),
    .a        (a),
    .b        (b),
    .c        (c),
    .op       (op),
    .rm       (rm),
    .outValid (outValid),
    .result   (result)
  );

  fmaChecker u_checker (
    .clk          (clk),
    .arstN        (arstN),
    .inValid      (inValid),
    .a            (a),
    .b            (b),
    .c            (c),
    .op           (op),
    .rm           (rm),
    .outValid     (outValid),
    .result       (result),
    .checkCount   (checks),
    .errorCount   (errors),
    .pendingCount (pending)
  );

  // one operation per falling edge
  task automatic issue(mini_t x, mini_t y, mini_t z, fmaOp_e o, roundMode_e m);
    @(negedge clk);
    inValid = 1'b1;
    a       = x;
    b       = y;
    c       = z;
    op      = o;
    rm      = m;
  endtask

  // stop issuing, wait for the pipe to drain, report
  task automatic finishTest(string name);
    int waited;
    waited = 0;
    @(negedge clk);
    inValid = 1'b0;
    while (pending != 0 && waited < 10) begin
      @(negedge clk);
      waited++;
    end
    if (pending != 0) begin
      $display("%s: %0d results never came out", name, pending);
      tbErrors++;
    end
    $display("%s: %0d results checked, %0d errors", name, checks - lastChecks,
             errors - lastErrors);
    lastChecks = checks;
    lastErrors = errors;
  endtask

  initial begin
    roundMode_e m;
    void'($urandom(32'h49c0c015));
    inValid    = 1'b0;
    a          = '0;
    b          = '0;
    c          = '0;
    op         = opFma;
    rm         = rne;
    tbErrors   = 0;
    lastChecks = 0;
    lastErrors = 0;
    wait (arstN === 1'b1);

    ////////////////////////////////////////////////////////////
    // directed normal values, nearest even
    ////////////////////////////////////////////////////////////
    issue(8'h3C, 8'h40, 8'h30, opFma, rne);
    issue(8'h45, 8'h3A, 8'h00, opMul, rne);
    issue(8'h48, 8'h00, 8'hB4, opAdd, rne);
    issue(8'h50, 8'h44, 8'hD2, opFma, rne);
    // addend far below, then far above the product
    issue(8'h3F, 8'h3F, 8'h08, opFma, rne);
    issue(8'h08, 8'h08, 8'h60, opFma, rne);
    issue(8'h29, 8'h4B, 8'hC1, opFma, rne);
    issue(8'h5E, 8'h9B, 8'h47, opMul, rne);
    finishTest("test 1 directed fma mul add");

    // ties, sticky only and mixed guard bits in every mode
    for (int i = 0; i < 5; i++) begin
      m = roundMode_e'(3'(i));
      issue(8'h38, 8'h00, 8'h18, opAdd, m);
      issue(8'h39, 8'h00, 8'h18, opAdd, m);
      issue(8'hB8, 8'h00, 8'h98, opAdd, m);
      issue(8'h39, 8'h39, 8'h00, opMul, m);
      issue(8'h3B, 8'hBB, 8'h00, opMul, m);
      issue(8'h3D, 8'h3B, 8'hB0, opFma, m);
      issue(8'h38, 8'h00, 8'h14, opAdd, m);
    end
    finishTest("test 2 rounding modes");

    ////////////////////////////////////////////////////////////
    // signed zeros and flush
    ////////////////////////////////////////////////////////////
    for (int i = 0; i < 5; i++) begin
      m = roundMode_e'(3'(i));
      issue(8'h3C, 8'h00, 8'hBC, opAdd, m);
      issue(8'h40, 8'h38, 8'hC0, opFma, m);
      // inexact product just under 2^-6
      issue(8'h0F, 8'h2B, 8'h00, opMul, m);
      issue(8'h8F, 8'h2B, 8'h00, opMul, m);
    end
    issue(8'h80, 8'h44, 8'h00, opMul, rne);
    issue(8'h00, 8'hC4, 8'h00, opMul, rup);
    issue(8'h80, 8'h44, 8'h00, opFma, rne);
    issue(8'h80, 8'h00, 8'h80, opAdd, rne);
    finishTest("test 3 signed zeros");

    // inf times zero, inf minus inf, infinite addend, NaN input
    issue(8'h78, 8'h00, 8'h38, opFma, rne);
    issue(8'h00, 8'hF8, 8'h38, opFma, rne);
    issue(8'h78, 8'h00, 8'hF8, opAdd, rne);
    issue(8'h40, 8'h78, 8'hF8, opFma, rne);
    issue(8'h38, 8'h38, 8'hF8, opFma, rne);
    issue(8'h44, 8'h00, 8'h78, opAdd, rne);
    issue(8'hF8, 8'h40, 8'h00, opMul, rdn);
    issue(8'h7D, 8'h38, 8'h38, opFma, rne);
    // overflow in every mode
    for (int i = 0; i < 5; i++) begin
      m = roundMode_e'(3'(i));
      issue(8'h70, 8'h70, 8'h00, opMul, m);
      issue(8'hF0, 8'h70, 8'h00, opMul, m);
      issue(8'h77, 8'h00, 8'h77, opAdd, m);
    end
    finishTest("test 4 specials and overflow");

    ////////////////////////////////////////////////////////////
    // random stream, new operation every cycle
    ////////////////////////////////////////////////////////////
    for (int i = 0; i < randomOps; i++) begin
      issue(8'($urandom), 8'($urandom), 8'($urandom),
            fmaOp_e'(2'($urandom % 3)), roundMode_e'(3'($urandom % 5)));
    end
    finishTest("test 5 back to back random");

    $display("all tests done: %0d results checked, %0d errors", checks, errors + tbErrors);
    if (errors == 0 && tbErrors == 0 && checks > 0) begin
      $display("TEST OK");
    end else begin
      $display("TEST FAILED");
    end
    $finish;
  end

  // watchdog
  initial begin
    #(limitCycles * clkPeriod);
    $display("watchdog expired after %0d cycles with tests still running", limitCycles);
    $display("TEST FAILED");
    $finish;
  end

endmodule

//--- test/fmaChecker.sv
// fma result checker
module fmaChecker (
  input  logic                clk,
  input  logic                arstN,
  input  logic                inValid,
  input  fpFormatPkg::mini_t  a,
  input  fpFormatPkg::mini_t  b,
  input  fpFormatPkg::mini_t  c,
  input  fpOpPkg::fmaOp_e     op,
  input  fpOpPkg::roundMode_e rm,
  input  logic                outValid,
  input  fpFormatPkg::mini_t  result,
  output int                  checkCount,
  output int                  errorCount,
  output int                  pendingCount
);
  timeunit 1ns;
  timeprecision 100ps;
  import fpFormatPkg::*;
  import fpOpPkg::*;

  mini_t expQ[$];
  int    dueQ[$];
  int    cycle;
  mini_t expVal;
  int    due;

  ////////////////////////////////////////////////////////////
  // reference model
  ////////////////////////////////////////////////////////////
  function automatic real pow2(int e);
    real p;
    p = 1.0;
    for (int i = 0; i < e; i++) begin
      p = p * 2.0;
    end
    for (int i = 0; i < -e; i++) begin
      p = p / 2.0;
    end
    return p;
  endfunction

  function automatic logic isInf(mini_t x);
    return x[fracW +: expW] == expW'(expMax) && x[fracW-1:0] == '0;
  endfunction

  function automatic logic isNaN(mini_t x);
    return x[fracW +: expW] == expW'(expMax) && x[fracW-1:0] != '0;
  endfunction

  // unsigned value where a zero exponent field reads as zero
  function automatic real magOf(mini_t x);
    int e;
    e = int'(x[fracW +: expW]);
    if (e == 0) begin
      return 0.0;
    end
    return real'(int'({1'b1, x[fracW-1:0]})) * pow2(e - expBias - fracW);
  endfunction

  // round a positive exact magnitude to 4 significant bits
  function automatic mini_t roundToMini(real v, logic s, roundMode_e m);
    int   e;
    int   q;
    int   biased;
    real  scaled;
    real  fracPart;
    logic up;
    e = 0;
    while (v >= pow2(e + 1)) begin
      e++;
    end
    while (v < pow2(e)) begin
      e--;
    end
    scaled   = v / pow2(e - fracW);
    q        = int'($floor(scaled));
    fracPart = scaled - real'(q);
    case (m)
      rne:     up = fracPart > 0.5 || (fracPart == 0.5 && q[0]);
      rdn:     up = s && fracPart > 0.0;
      rup:     up = !s && fracPart > 0.0;
      rmm:     up = fracPart >= 0.5;
      default: up = 1'b0;
    endcase
    if (up) begin
      q++;
    end
    // significand carry turns 1.111 into 10.000
    if (q == 16) begin
      q = 8;
      e++;
    end
    biased = e + expBias;
    if (biased >= expMax) begin
      if (m == rtz || (m == rdn && !s) || (m == rup && s)) begin
        return {s, maxFinite[expW+fracW-1:0]};
      end
      return {s, posInf[expW+fracW-1:0]};
    end
    if (biased < 1) begin
      return {s, 7'h00};
    end
    return {s, 4'(biased), 3'(q - 8)};
  endfunction

  function automatic mini_t refFma(mini_t x, mini_t y, mini_t z, fmaOp_e o, roundMode_e m);
    mini_t yEff;
    mini_t zEff;
    logic  pSign;
    logic  zSign;
    logic  pInf;
    logic  pZero;
    real   v;
    // add is x*1.0+z, mul is x*y+0
    yEff  = (o == opAdd) ? miniOne : y;
    zEff  = (o == opMul) ? mini_t'(0) : z;
    pSign = x[7] ^ yEff[7];
    zSign = zEff[7];
    pInf  = isInf(x) | isInf(yEff);
    pZero = magOf(x) == 0.0 || magOf(yEff) == 0.0;
    if (isNaN(x) || isNaN(yEff) || isNaN(zEff)) begin
      return canonNaN;
    end
    if ((pInf && pZero) || (pInf && isInf(zEff) && pSign != zSign)) begin
      return canonNaN;
    end
    if (pInf) begin
      return {pSign, posInf[expW+fracW-1:0]};
    end
    if (isInf(zEff)) begin
      return {zSign, posInf[expW+fracW-1:0]};
    end
    v = (pSign ? -1.0 : 1.0) * magOf(x) * magOf(yEff) + (zSign ? -1.0 : 1.0) * magOf(zEff);
    if (v == 0.0) begin
      // plain product or like signs keep the product sign
      if (o == opMul || pSign == zSign) begin
        return {pSign, 7'h00};
      end
      return {m == rdn, 7'h00};
    end
    if (v > 0.0) begin
      return roundToMini(v, 1'b0, m);
    end
    return roundToMini(-v, 1'b1, m);
  endfunction

  ////////////////////////////////////////////////////////////
  // expected queue and compare
  ////////////////////////////////////////////////////////////
  always @(posedge clk) begin
    if (!arstN) begin
      cycle        = 0;
      checkCount   = 0;
      errorCount   = 0;
      pendingCount = 0;
    end else begin
      cycle = cycle + 1;
      if (outValid) begin
        if (expQ.size() == 0) begin
          $display("%0t: a result came out with no operation outstanding", $time);
          errorCount++;
        end else begin
          expVal = expQ.pop_front();
          due    = dueQ.pop_front();
          checkCount++;
          if (result !== expVal) begin
            $display("FAILED time=%0t result expected=%h actual=%h", $time, expVal, result);
            errorCount++;
          end
          if (cycle != due) begin
            $display("%0t: result seen at edge %0d but expected at edge %0d",
                     $time, cycle, due);
            errorCount++;
          end
        end
      end
      // outValid shows up three edges after its inValid
      if (inValid) begin
        expQ.push_back(refFma(a, b, c, op, rm));
        dueQ.push_back(cycle + 3);
      end
      pendingCount = expQ.size();
    end
  end

endmodule

//--- test/tbClock.sv
// testbench clock and reset
module tbClock #(
  parameter int period      = 20,
  parameter int resetCycles = 4
) (
  output logic clk,
  output logic arstN
);
  timeunit 1ns;
  timeprecision 100ps;

  initial begin
    clk   = 1'b0;
    arstN = 1'b0;
    repeat (resetCycles) @(posedge clk);
    // release between active edges
    @(negedge clk);
    arstN = 1'b1;
  end

  always #(period / 2) clk = ~clk;

endmodule

//--- logic/miniFma.sv
// minifloat fused multiply-add
module miniFma (
  input  logic                clk,
  input  logic                arstN,
  input  logic                inValid,
  input  fpFormatPkg::mini_t  a,
  input  fpFormatPkg::mini_t  b,
  input  fpFormatPkg::mini_t  c,
  input  fpOpPkg::fmaOp_e     op,
  input  fpOpPkg::roundMode_e rm,
  output logic                outValid,
  output fpFormatPkg::mini_t  result
);

  // three registered stages, one result per cycle, latency 3
  mulSumIf   mulSum ();
  sumRoundIf sumRound ();

  // unpack, multiply, align
  fmaMul u_fmaMul (
    .clk     (clk),
    .arstN   (arstN),
    .inValid (inValid),
    .a       (a),
    .b       (b),
    .c       (c),
    .op      (op),
    .rm      (rm),
    .mulSum  (mulSum)
  );

  // add and leading zero count
  fmaSum u_fmaSum (
    .clk      (clk),
    .arstN    (arstN),
    .mulSum   (mulSum),
    .sumRound (sumRound)
  );

  // normalize, round, sign, specials
  fmaRound u_fmaRound (
    .clk      (clk),
    .arstN    (arstN),
    .sumRound (sumRound),
    .outValid (outValid),
    .result   (result)
  );

endmodule

//--- logic/fmaRound.sv
// fma normalize and round stage
module fmaRound (
  input  logic               clk,
  input  logic               arstN,
  sumRoundIf.sum             sumRound,
  output logic               outValid,
  output fpFormatPkg::mini_t result
);
  import fpFormatPkg::*;
  import fpOpPkg::*;

  sum_t              normSig;
  logic              lsb;
  logic              guardBit;
  logic              roundBit;
  logic              stickyBit;
  logic              inexact;
  logic              roundUp;
  logic              toMax;
  logic              mult;
  logic              rs;
  logic [fracW+1:0]  roundedSig;
  logic signed [7:0] baseWide;
  logic signed [7:0] normExp;
  logic signed [7:0] finalExp;
  mini_t             resultNext;

  ////////////////////////////////////////////////////////////
  // normalize
  ////////////////////////////////////////////////////////////
  // leading one lands on the window msb
  assign normSig   = sumRound.sumMag << sumRound.lzc;
  assign lsb       = normSig[alignW-fracW-1];
  assign guardBit  = normSig[alignW-fracW-2];
  assign roundBit  = normSig[alignW-fracW-3];
  assign stickyBit = |normSig[alignW-fracW-4:0];
  assign inexact   = guardBit | roundBit | stickyBit;

  // sign extend before the exponent math
  assign baseWide = sumRound.baseExp;
  assign normExp  = baseWide + 8'(leadOff) - 8'(sumRound.lzc);

  assign mult = sumRound.op == opMul;

  resultSign u_resultSign (
    .rm       (sumRound.rm),
    .fmaOp    (~mult),
    .mult     (mult),
    .zInf     (sumRound.zInf),
    .infIn    (sumRound.infIn),
    .sumZero  (sumRound.sumZero),
    .ms       (sumRound.sumSign),
    .prodSign (sumRound.prodSign),
    .addSign  (sumRound.addSign),
    .guard    (guardBit),
    .round    (roundBit),
    .sticky   (stickyBit),
    .rs       (rs)
  );

  ////////////////////////////////////////////////////////////
  // round by mode
  ////////////////////////////////////////////////////////////
  always_comb begin
    case (sumRound.rm)
      rne:     roundUp = guardBit & (roundBit | stickyBit | lsb);
      rtz:     roundUp = 1'b0;
      rdn:     roundUp = rs & inexact;
      rup:     roundUp = ~rs & inexact;
      rmm:     roundUp = guardBit;
      default: roundUp = 1'b0;
    endcase
  end

  // carry out of the significand bumps the exponent, fraction reads 000
  assign roundedSig = {1'b0, normSig[alignW-1 -: fracW+1]} + (fracW+2)'(roundUp);
  assign finalExp   = normExp + 8'(roundedSig[fracW+1]);

  // overflow saturates when rounding toward zero magnitude
  assign toMax = (sumRound.rm == rtz) || (sumRound.rm == rdn && !rs) ||
                 (sumRound.rm == rup && rs);

  always_comb begin
    if (sumRound.anyNaN || sumRound.invalid) begin
      resultNext = canonNaN;
    end else if (sumRound.infIn) begin
      resultNext = {rs, posInf[expW+fracW-1:0]};
    end else if (sumRound.sumZero) begin
      resultNext = {rs, {(expW+fracW){1'b0}}};
    end else if (finalExp >= expMax) begin
      resultNext = {rs, toMax ? maxFinite[expW+fracW-1:0] : posInf[expW+fracW-1:0]};
    end else if (finalExp < 1) begin
      // below 2^-6 after rounding, flush
      resultNext = {rs, {(expW+fracW){1'b0}}};
    end else begin
      resultNext = {rs, finalExp[expW-1:0], roundedSig[fracW-1:0]};
    end
  end

  always_ff @(posedge clk or negedge arstN) begin
    if (!arstN) begin
      outValid <= 1'b0;
    end else begin
      outValid <= sumRound.valid;
    end
  end

  always_ff @(posedge clk) begin
    if (sumRound.valid) begin
      result <= resultNext;
    end
  end

endmodule

//--- logic/resultSign.sv
// fma result sign select
module resultSign (
  input  fpOpPkg::roundMode_e rm,
  input  logic                fmaOp,
  input  logic                mult,
  input  logic                zInf,
  input  logic                infIn,
  input  logic                sumZero,
  input  logic                ms,
  input  logic                prodSign,
  input  logic                addSign,
  input  logic                guard,
  input  logic                round,
  input  logic                sticky,
  output logic                rs
);
  import fpOpPkg::*;

  logic zeroSign;
  logic infSign;

  // exact cancellation of opposite signs is +0, -0 only when rounding down
  // a product or an inexact zero keeps the product sign
  assign zeroSign = ((prodSign ^ addSign) & ~(guard | round | sticky) & ~mult) ?
                    (rm == rdn) : prodSign;

  // infinite addend wins, else the infinite product
  assign infSign = zInf ? addSign : prodSign;

  always_comb begin
    if (infIn & fmaOp) begin
      rs = infSign;
    end else if (sumZero & fmaOp) begin
      rs = zeroSign;
    end else begin
      rs = ms;
    end
  end

endmodule

//--- logic/fmaSum.sv
// fma add and leading zero stage
module fmaSum (
  input  logic    clk,
  input  logic    arstN,
  mulSumIf.sum    mulSum,
  sumRoundIf.prod sumRound
);
  import fpFormatPkg::*;

  sum_t prodAl;
  sum_t addAl;
  sum_t sumNext;
  logic msNext;

  // scan from the lsb so the highest set bit wins
  function automatic lzc_t countLz(sum_t x);
    lzc_t n;
    n = lzc_t'(alignW);
    for (int i = 0; i < alignW; i++) begin
      if (x[i]) begin
        n = lzc_t'(alignW - 1 - i);
      end
    end
    return n;
  endfunction

  ////////////////////////////////////////////////////////////
  // place operands in the window
  ////////////////////////////////////////////////////////////
  assign prodAl = sum_t'(mulSum.prodSig) << prodLsb;
  // addend msb starts at addTop, killed addend keeps only a sticky lsb
  assign addAl  = mulSum.addKilled ? sum_t'(1) :
                  (sum_t'(mulSum.addSig) << (addTop - fracW)) >> mulSum.alignShift;

  // magnitude add, larger magnitude sets Ms
  always_comb begin
    if (!mulSum.effSub) begin
      sumNext = prodAl + addAl;
      msNext  = mulSum.prodSign;
    end else if (addAl > prodAl) begin
      sumNext = addAl - prodAl;
      msNext  = mulSum.addSign;
    end else begin
      sumNext = prodAl - addAl;
      msNext  = mulSum.prodSign;
    end
  end

  ////////////////////////////////////////////////////////////
  // stage register
  ////////////////////////////////////////////////////////////
  always_ff @(posedge clk or negedge arstN) begin
    if (!arstN) begin
      sumRound.valid <= 1'b0;
    end else begin
      sumRound.valid <= mulSum.valid;
    end
  end

  always_ff @(posedge clk) begin
    if (mulSum.valid) begin
      sumRound.sumMag   <= sumNext;
      sumRound.sumSign  <= msNext;
      sumRound.sumZero  <= sumNext == '0;
      sumRound.lzc      <= countLz(sumNext);
      sumRound.baseExp  <= mulSum.baseExp;
      sumRound.prodSign <= mulSum.prodSign;
      sumRound.addSign  <= mulSum.addSign;
      sumRound.op       <= mulSum.op;
      sumRound.rm       <= mulSum.rm;
      sumRound.anyNaN   <= mulSum.anyNaN;
      sumRound.invalid  <= mulSum.invalid;
      sumRound.zInf     <= mulSum.zInf;
      sumRound.infIn    <= mulSum.infIn;
    end
  end

endmodule

//--- logic/fmaMul.sv
// fma multiply and align stage
module fmaMul (
  input  logic                clk,
  input  logic                arstN,
  input  logic                inValid,
  input  fpFormatPkg::mini_t  a,
  input  fpFormatPkg::mini_t  b,
  input  fpFormatPkg::mini_t  c,
  input  fpOpPkg::fmaOp_e     op,
  input  fpOpPkg::roundMode_e rm,
  mulSumIf.prod               mulSum
);
  import fpFormatPkg::*;
  import fpOpPkg::*;

  mini_t             bEff;
  mini_t             cEff;
  logic              aZero, bZero, cZero;
  logic              aInf, bInf, cInf;
  logic              aNaN, bNaN, cNaN;
  logic              prodSign;
  logic              effSub;
  logic              prodZero;
  logic signed [6:0] pExp;
  logic signed [6:0] cBase;
  logic signed [6:0] rawShift;
  logic [4:0]        shiftNext;
  logic              killNext;
  exp_t              baseNext;

  function automatic logic [expW-1:0] expOf(mini_t x);
    return x[fracW +: expW];
  endfunction

  // hidden one added, a zero exponent field reads as zero
  function automatic sig_t sigOf(mini_t x);
    return (expOf(x) == '0) ? sig_t'(0) : {1'b1, x[fracW-1:0]};
  endfunction

  ////////////////////////////////////////////////////////////
  // operand unpack and classify
  ////////////////////////////////////////////////////////////
  // add and mul reuse the fma datapath
  assign bEff = (op == opAdd) ? miniOne : b;
  assign cEff = (op == opMul) ? '0 : c;

  assign aZero = expOf(a) == '0;
  assign bZero = expOf(bEff) == '0;
  assign cZero = expOf(cEff) == '0;
  assign aInf  = expOf(a) == expMax && a[fracW-1:0] == '0;
  assign bInf  = expOf(bEff) == expMax && bEff[fracW-1:0] == '0;
  assign cInf  = expOf(cEff) == expMax && cEff[fracW-1:0] == '0;
  assign aNaN  = expOf(a) == expMax && a[fracW-1:0] != '0;
  assign bNaN  = expOf(bEff) == expMax && bEff[fracW-1:0] != '0;
  assign cNaN  = expOf(cEff) == expMax && cEff[fracW-1:0] != '0;

  assign prodSign = a[expW+fracW] ^ bEff[expW+fracW];
  assign effSub   = prodSign ^ cEff[expW+fracW];
  assign prodZero = aZero | bZero;

  ////////////////////////////////////////////////////////////
  // exponent difference and align shift
  ////////////////////////////////////////////////////////////
  // biased product exponent and the scale set by the addend alone
  assign pExp     = $signed({3'b0, expOf(a)}) + $signed({3'b0, expOf(bEff)}) - 7'(expBias);
  assign cBase    = $signed({3'b0, expOf(cEff)}) - 7'(addOff);
  assign rawShift = pExp - cBase;

  always_comb begin
    shiftNext = '0;
    killNext  = 1'b0;
    baseNext  = exp_t'(pExp);
    if (!cZero) begin
      if (prodZero || rawShift < 0) begin
        // addend far above so the product only reaches sticky
        baseNext = exp_t'(cBase);
      end else if (rawShift > addTop - prodLsb) begin
        // whole addend below the product lsb
        killNext = 1'b1;
      end else begin
        shiftNext = rawShift[4:0];
      end
    end
  end

  ////////////////////////////////////////////////////////////
  // stage register
  ////////////////////////////////////////////////////////////
  always_ff @(posedge clk or negedge arstN) begin
    if (!arstN) begin
      mulSum.valid <= 1'b0;
    end else begin
      mulSum.valid <= inValid;
    end
  end

  always_ff @(posedge clk) begin
    if (inValid) begin
      mulSum.prodSign   <= prodSign;
      mulSum.addSign    <= cEff[expW+fracW];
      mulSum.effSub     <= effSub;
      mulSum.prodSig    <= prod_t'(sigOf(a)) * prod_t'(sigOf(bEff));
      mulSum.addSig     <= sigOf(cEff);
      mulSum.alignShift <= shiftNext;
      mulSum.addKilled  <= killNext;
      mulSum.baseExp    <= baseNext;
      mulSum.op         <= op;
      mulSum.rm         <= rm;
      mulSum.anyNaN     <= aNaN | bNaN | cNaN;
      // inf times zero, or inf minus inf
      mulSum.invalid    <= (aInf & bZero) | (aZero & bInf) | ((aInf | bInf) & cInf & effSub);
      mulSum.zInf       <= cInf;
      mulSum.infIn      <= aInf | bInf | cInf;
    end
  end

endmodule

//--- logic/fmaStageIfs.sv
// fma stage interfaces

// multiply stage to sum stage
interface mulSumIf;
  import fpFormatPkg::*;
  import fpOpPkg::*;

  logic       valid;
  logic       prodSign;
  logic       addSign;
  logic       effSub;
  prod_t      prodSig;
  sig_t       addSig;
  logic [4:0] alignShift;
  // addend shifted out completely, stands in as a sticky lsb
  logic       addKilled;
  exp_t       baseExp;
  fmaOp_e     op;
  roundMode_e rm;
  logic       anyNaN;
  logic       invalid;
  logic       zInf;
  logic       infIn;

  modport prod (output valid, prodSign, addSign, effSub, prodSig, addSig, alignShift,
                addKilled, baseExp, op, rm, anyNaN, invalid, zInf, infIn);
  modport sum  (input valid, prodSign, addSign, effSub, prodSig, addSig, alignShift,
                addKilled, baseExp, op, rm, anyNaN, invalid, zInf, infIn);
endinterface

// sum stage to round stage
interface sumRoundIf;
  import fpFormatPkg::*;
  import fpOpPkg::*;

  logic       valid;
  sum_t       sumMag;
  logic       sumSign;
  logic       sumZero;
  lzc_t       lzc;
  exp_t       baseExp;
  logic       prodSign;
  logic       addSign;
  fmaOp_e     op;
  roundMode_e rm;
  logic       anyNaN;
  logic       invalid;
  logic       zInf;
  logic       infIn;

  modport prod (output valid, sumMag, sumSign, sumZero, lzc, baseExp, prodSign, addSign,
                op, rm, anyNaN, invalid, zInf, infIn);
  modport sum  (input valid, sumMag, sumSign, sumZero, lzc, baseExp, prodSign, addSign,
                op, rm, anyNaN, invalid, zInf, infIn);
endinterface

//--- logic/fpOpPkg.sv
// fma operation package
package fpOpPkg;

  ////////////////////////////////////////////////////////////
  // operation select
  ////////////////////////////////////////////////////////////
  // add runs as a*1.0+c and mul runs as a*b+0
  typedef enum logic [1:0] {
    opFma = 2'd0,
    opMul = 2'd1,
    opAdd = 2'd2
  } fmaOp_e;

  ////////////////////////////////////////////////////////////
  // rounding modes, RISC-V frm encoding
  ////////////////////////////////////////////////////////////
  typedef enum logic [2:0] {
    rne = 3'd0,
    rtz = 3'd1,
    rdn = 3'd2,
    rup = 3'd3,
    rmm = 3'd4
  } roundMode_e;

endpackage

//--- logic/fpFormatPkg.sv
// minifloat format package
package fpFormatPkg;

  // 1 sign, 4 exponent and 3 fraction bits
  localparam int expW    = 4;
  localparam int fracW   = 3;
  localparam int expBias = 7;
  // all ones exponent field marks inf and NaN
  localparam int expMax  = (1 << expW) - 1;

  ////////////////////////////////////////////////////////////
  // aligned sum window
  ////////////////////////////////////////////////////////////
  localparam int alignW  = 20;
  // product lsb position, window bit binPt weighs 2^baseExp
  localparam int prodLsb = 3;
  localparam int binPt   = prodLsb + 2 * fracW;
  // msb of the addend before the right shift
  localparam int addTop  = 17;
  localparam int addOff  = addTop - binPt;
  // exponent of the window msb above baseExp
  localparam int leadOff = alignW - 1 - binPt;

  typedef logic [expW+fracW:0] mini_t;
  // signed so that under- and overflow stay visible
  typedef logic signed [5:0]   exp_t;
  typedef logic [fracW:0]      sig_t;
  typedef logic [2*fracW+1:0]  prod_t;
  typedef logic [alignW-1:0]   sum_t;
  typedef logic [4:0]          lzc_t;

  // fixed encodings
  localparam mini_t canonNaN  = 8'h7C;
  localparam mini_t posInf    = 8'h78;
  localparam mini_t maxFinite = 8'h77;
  localparam mini_t miniOne   = 8'h38;

endpackage
